//--- Makefile
# Verilator build and run for the decode stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -qx "PASS: all tests" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_decode_stage.sv
`timescale 1ns/10ps

module tb_decode_stage;

  logic                                                          clk;
  logic                                                          reset;
  decode_pkg::fetch_bundle_t                                     fetch_bundle;
  logic                                                          fetch_valid;
  logic                                                          fetch_ready;
  logic [decode_pkg::issue_width-1:0][decode_pkg::rob_tag_w-1:0] rob_tags;
  logic                                                          rob_full;
  logic                                                          iq_full;
  logic                                                          stall;
  logic                                                          dispatch;
  logic [1:0]                                                    dispatch_count;
  decode_pkg::iq_entry_t [decode_pkg::issue_width-1:0]           iq_entries;

  logic [31:0]                      stim_state;
  logic [31:0]                      stall_state;
  logic                             random_stall;
  logic [31:0]                      next_pc;
  logic [decode_pkg::rob_tag_w-1:0] rob_tail;
  logic [decode_pkg::rob_tag_w-1:0] exp_tail;
  decode_pkg::fetch_bundle_t        pending_q[$];  // Accepted bundles with a valid lane.
  int                               errors;
  int                               timeouts;
  int                               accepted;
  int                               dispatched;

  decode_stage dut (
    .clk            (clk),
    .reset          (reset),
    .fetch_bundle   (fetch_bundle),
    .fetch_valid    (fetch_valid),
    .fetch_ready    (fetch_ready),
    .rob_tags       (rob_tags),
    .rob_full       (rob_full),
    .iq_full        (iq_full),
    .stall          (stall),
    .dispatch       (dispatch),
    .dispatch_count (dispatch_count),
    .iq_entries     (iq_entries)
  );

  always #4 clk = ~clk;

  // The ROB offers the next four tags from its tail.
  always_comb begin
    for (int k = 0; k < decode_pkg::issue_width; k++) begin
      rob_tags[k] = rob_tail + decode_pkg::rob_tag_w'(k);
    end
  end

  always @(posedge clk) begin
    #1;
    if (random_stall) begin
      stall_state = lcg(stall_state);
      rob_full    = (stall_state[9:8] == 2'd0);
      iq_full     = (stall_state[13:12] == 2'd0);
    end else begin
      rob_full = 1'b0;
      iq_full  = 1'b0;
    end
  end

  // ==========================================================================
  // Reference model
  // ==========================================================================

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_random();
    stim_state = lcg(stim_state);
    return stim_state;
  endfunction

  function automatic decode_pkg::dec_inst_t decode_word(input logic [31:0] pc,
                                                        input logic [31:0] w);
    decode_pkg::dec_inst_t d;
    logic [4:0]            uses;  // Dest, A, B, C, immediate.
    d    = '0;
    d.pc = pc;
    case (w[31:29])
      3'd0:    uses = 5'b11100;
      3'd1:    uses = 5'b11001;
      3'd2:    uses = 5'b11001;
      3'd3:    uses = 5'b01011;
      3'd4:    uses = 5'b01101;
      default: uses = 5'b00000;
    endcase
    if (w[31:29] > 3'd4) d.cls = decode_pkg::cls_nop;
    else d.cls = decode_pkg::inst_class_e'(w[31:29]);
    d.dest_valid = uses[4];
    d.a_used     = uses[3];
    d.b_used     = uses[2];
    d.c_used     = uses[1];
    if (uses[4]) d.dest_reg = w[25:21];
    if (uses[3]) d.a_reg = w[20:16];
    if (uses[2]) d.b_reg = w[15:11];
    if (uses[1]) d.c_reg = w[10:6];
    if (uses[0]) d.imm = {{16{w[15]}}, w[15:0]};
    return d;
  endfunction

  // Valid lanes in ascending order, tagged from the tail.
  function automatic void ref_dispatch(
    input  decode_pkg::fetch_bundle_t                           b,
    input  logic [decode_pkg::rob_tag_w-1:0]                    tail,
    output decode_pkg::iq_entry_t [decode_pkg::issue_width-1:0] want,
    output int                                                  n
  );
    want = '0;
    n    = 0;
    for (int i = 0; i < decode_pkg::issue_width; i++) begin
      if (b.lane_valid[i]) begin
        want[n].inst    = decode_word(b.pc[i], b.word[i]);
        want[n].rob_tag = tail + decode_pkg::rob_tag_w'(n);
        n++;
      end
    end
  endfunction

  function automatic decode_pkg::fetch_bundle_t make_bundle(input logic [3:0] mask);
    decode_pkg::fetch_bundle_t b;
    b.lane_valid = mask;
    for (int i = 0; i < decode_pkg::issue_width; i++) begin
      b.pc[i]   = next_pc + 32'(4 * i);
      b.word[i] = next_random();
    end
    next_pc = next_pc + 32'd16;
    return b;
  endfunction

  // ==========================================================================
  // Checks
  // ==========================================================================

  task automatic report_error(input string msg);
    errors++;
    $display("** Error at %0t: %s", $time, msg);
  endtask

  task automatic check_entry(input int k, input decode_pkg::iq_entry_t got,
                             input decode_pkg::iq_entry_t want);
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: iq_entries[%0d] is %h, expected %h", $time, k, got, want);
    end
  endtask

  task automatic check_count(input logic [1:0] got, input logic [1:0] want);
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: dispatch_count is %0d, expected %0d", $time, got, want);
    end
  endtask

  always @(negedge clk) begin : compare
    decode_pkg::iq_entry_t [decode_pkg::issue_width-1:0] want;
    decode_pkg::fetch_bundle_t                           b;
    int                                                  n;
    if (!reset) begin
      if (stall !== (rob_full | iq_full)) report_error("stall differs from rob_full | iq_full");
      if (dispatch === 1'b1 && stall !== 1'b0) report_error("dispatch while stalled");
      if (dispatch === 1'b1) begin
        dispatched++;
        if (pending_q.size() == 0) begin
          report_error("dispatch with no bundle pending");
        end else begin
          b = pending_q.pop_front();
          ref_dispatch(b, exp_tail, want, n);
          check_count(dispatch_count, 2'(n - 1));
          for (int k = 0; k < n; k++) begin
            check_entry(k, iq_entries[k], want[k]);
          end
          exp_tail = exp_tail + decode_pkg::rob_tag_w'(n);
        end
        rob_tail = rob_tail + decode_pkg::rob_tag_w'(dispatch_count) + 1'b1;
      end
      if (fetch_valid && fetch_ready && fetch_bundle.lane_valid != '0) begin
        pending_q.push_back(fetch_bundle);
        accepted++;
      end
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  task automatic finish_run();
    $display("Done: %0d errors, %0d timeouts, %0d bundles dispatched",
             errors, timeouts, dispatched);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // Called 1 ns after a rising edge and returns 1 ns after the transfer edge.
  task automatic send_bundle(input decode_pkg::fetch_bundle_t b);
    int waited;
    waited       = 0;
    fetch_bundle = b;
    fetch_valid  = 1'b1;
    @(negedge clk);
    while (!fetch_ready && waited < 200) begin
      waited++;
      @(negedge clk);
    end
    if (!fetch_ready) begin
      $display("Timeout: fetch_ready stayed low for %0d cycles", waited);
      timeouts++;
      finish_run();
    end else begin
      @(posedge clk);
      #1;
      fetch_valid = 1'b0;
    end
  endtask

  // Returns on a falling edge once every pending bundle has left.
  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (pending_q.size() != 0 && waited < 200) begin
      waited++;
      @(negedge clk);
    end
    if (pending_q.size() != 0) begin
      $display("Timeout: %0d bundles never dispatched", pending_q.size());
      timeouts++;
      finish_run();
    end
  endtask

  task automatic stream_bundles(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = next_random();
      fetch_bundle = make_bundle((r[3:0] == 4'd0) ? 4'b1000 : r[3:0]);
      fetch_valid  = 1'b1;
      @(negedge clk);
      if (fetch_ready !== 1'b1) report_error("fetch_ready low with no stall");
      if (i > 0 && dispatch !== 1'b1) report_error("no dispatch one cycle after accept");
      @(posedge clk);
      #1;
    end
    fetch_valid = 1'b0;
    @(negedge clk);
    if (dispatch !== 1'b1) report_error("no dispatch for the last streamed bundle");
  endtask

  initial begin
    decode_pkg::fetch_bundle_t b;
    logic [31:0]               r;
    clk          = 1'b0;
    reset        = 1'b1;
    fetch_bundle = '0;
    fetch_valid  = 1'b0;
    rob_full     = 1'b0;
    iq_full      = 1'b0;
    random_stall = 1'b0;
    stim_state   = 32'hd37f_544f;
    stall_state  = lcg(32'hd37f_544f);
    next_pc      = 32'h0000_1000;
    rob_tail     = '0;
    exp_tail     = '0;
    errors       = 0;
    timeouts     = 0;
    accepted     = 0;
    dispatched   = 0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    if (dispatch !== 1'b0 || fetch_ready !== 1'b1) report_error("wrong idle state after reset");
    @(posedge clk);
    #1;

    // Every class code, one lane at a time, moving across the lanes.
    for (int c = 0; c < 8; c++) begin
      b = make_bundle(4'b0001 << (c % 4));
      b.word[c % 4][31:29] = 3'(c);
      send_bundle(b);
    end
    wait_drain();
    @(posedge clk);
    #1;

    for (int m = 0; m < 16; m++) begin
      send_bundle(make_bundle(4'(m)));
    end
    wait_drain();

    random_stall = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < 150; i++) begin
      r = next_random();
      if (r[2:0] == 3'd0) begin
        @(posedge clk);  // Fetch bubble.
        #1;
      end else begin
        send_bundle(make_bundle(r[11:8]));
      end
    end
    wait_drain();
    random_stall = 1'b0;
    @(posedge clk);
    #1;

    stream_bundles(40);
    wait_drain();
    if (dispatched != accepted) begin
      report_error($sformatf("%0d dispatches for %0d accepted bundles", dispatched, accepted));
    end
    finish_run();
  end

endmodule

//--- src.f
verilog/decode_pkg.sv
verilog/fetch_bundle_buffer.sv
verilog/inst_decoder.sv
verilog/dispatch_compactor.sv
verilog/decode_stage.sv
sim/tb_decode_stage.sv

//--- verilog/decode_pkg.sv
package decode_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================

  localparam int issue_width = 4;
  localparam int reg_idx_w   = 5;
  localparam int rob_tag_w   = 4;
  localparam int xlen        = 32;
  localparam int opcode_w    = 6;
  localparam int imm_w       = 16;
  localparam int cnt_w       = $clog2(issue_width + 1);  // Holds 0 to issue_width.

  // ==========================================================================
  // Opcodes and classes
  // ==========================================================================

  // The upper three opcode bits select the class.
  typedef enum logic [opcode_w-1:0] {
    op_add   = 6'o00,
    op_sub   = 6'o01,
    op_and   = 6'o02,
    op_addi  = 6'o10,
    op_load  = 6'o20,
    op_store = 6'o30,
    op_beq   = 6'o40,
    op_bne   = 6'o41,
    op_nop   = 6'o70
  } opcode_e;

  typedef enum logic [2:0] {
    cls_alu     = 3'd0,
    cls_alu_imm = 3'd1,
    cls_load    = 3'd2,
    cls_store   = 3'd3,
    cls_branch  = 3'd4,
    cls_nop     = 3'd7
  } inst_class_e;

  typedef struct packed {
    logic dest;
    logic a;
    logic b;
    logic c;
    logic imm;
  } class_use_t;

  // Register and immediate usage per class.
  function automatic class_use_t class_use(inst_class_e cls);
    case (cls)
      cls_alu:     return '{dest: 1'b1, a: 1'b1, b: 1'b1, c: 1'b0, imm: 1'b0};
      cls_alu_imm: return '{dest: 1'b1, a: 1'b1, b: 1'b0, c: 1'b0, imm: 1'b1};
      cls_load:    return '{dest: 1'b1, a: 1'b1, b: 1'b0, c: 1'b0, imm: 1'b1};
      cls_store:   return '{dest: 1'b0, a: 1'b1, b: 1'b0, c: 1'b1, imm: 1'b1};
      cls_branch:  return '{dest: 1'b0, a: 1'b1, b: 1'b1, c: 1'b0, imm: 1'b1};
      default:     return '0;
    endcase
  endfunction

  // ==========================================================================
  // Bundles and entries
  // ==========================================================================

  typedef struct packed {
    logic [issue_width-1:0][xlen-1:0] pc;
    logic [issue_width-1:0][xlen-1:0] word;
    logic [issue_width-1:0]           lane_valid;
  } fetch_bundle_t;

  typedef struct packed {
    inst_class_e          cls;
    logic [reg_idx_w-1:0] dest_reg;
    logic                 dest_valid;
    logic [reg_idx_w-1:0] a_reg;
    logic                 a_used;
    logic [reg_idx_w-1:0] b_reg;
    logic                 b_used;
    logic [reg_idx_w-1:0] c_reg;
    logic                 c_used;
    logic [xlen-1:0]      imm;
    logic [xlen-1:0]      pc;
  } dec_inst_t;

  typedef struct packed {
    dec_inst_t            inst;
    logic [rob_tag_w-1:0] rob_tag;
  } iq_entry_t;

endpackage

//--- verilog/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                                                         clk,
  input  logic                                                         reset,
  input  decode_pkg::fetch_bundle_t                                    fetch_bundle,
  input  logic                                                         fetch_valid,
  output logic                                                         fetch_ready,
  input  logic [decode_pkg::issue_width-1:0][decode_pkg::rob_tag_w-1:0] rob_tags,
  input  logic                                                         rob_full,
  input  logic                                                         iq_full,
  output logic                                                         stall,
  output logic                                                         dispatch,
  output logic [1:0]                                                   dispatch_count,
  output decode_pkg::iq_entry_t [decode_pkg::issue_width-1:0]          iq_entries
);

  decode_pkg::fetch_bundle_t                         held_bundle;
  logic                                              held_valid;
  logic                                              pop;
  decode_pkg::dec_inst_t [decode_pkg::issue_width-1:0] dec_lanes;

  fetch_bundle_buffer u_buffer (
    .clk         (clk),
    .reset       (reset),
    .in_bundle   (fetch_bundle),
    .in_valid    (fetch_valid),
    .in_ready    (fetch_ready),
    .held_bundle (held_bundle),
    .held_valid  (held_valid),
    .pop         (pop)
  );

  // One decoder per lane.
  for (genvar i = 0; i < decode_pkg::issue_width; i++) begin : g_lane
    inst_decoder u_dec (
      .pc        (held_bundle.pc[i]),
      .inst_word (held_bundle.word[i]),
      .di        (dec_lanes[i])
    );
  end

  dispatch_compactor u_compactor (
    .lane_valid     (held_bundle.lane_valid),
    .held_valid     (held_valid),
    .dec_lanes      (dec_lanes),
    .rob_tags       (rob_tags),
    .rob_full       (rob_full),
    .iq_full        (iq_full),
    .stall          (stall),
    .pop            (pop),
    .dispatch       (dispatch),
    .dispatch_count (dispatch_count),
    .iq_entries     (iq_entries)
  );

endmodule

//--- verilog/dispatch_compactor.sv
`timescale 1ns/10ps

module dispatch_compactor (
  input  logic [decode_pkg::issue_width-1:0]                           lane_valid,
  input  logic                                                         held_valid,
  input  decode_pkg::dec_inst_t [decode_pkg::issue_width-1:0]          dec_lanes,
  input  logic [decode_pkg::issue_width-1:0][decode_pkg::rob_tag_w-1:0] rob_tags,
  input  logic                                                         rob_full,
  input  logic                                                         iq_full,
  output logic                                                         stall,
  output logic                                                         pop,
  output logic                                                         dispatch,
  output logic [1:0]                                                   dispatch_count,
  output decode_pkg::iq_entry_t [decode_pkg::issue_width-1:0]          iq_entries
);

  logic [decode_pkg::issue_width-1:0][decode_pkg::cnt_w-1:0] lane_rank;
  logic [decode_pkg::cnt_w-1:0] valid_count;
  logic [decode_pkg::cnt_w-1:0] count_m1;
  logic                         any_valid;

  // ==========================================================================
  // Lane ranks and count
  // ==========================================================================

  // Rank of a lane is the number of valid lanes below it.
  always_comb begin
    lane_rank[0] = '0;
    for (int i = 1; i < decode_pkg::issue_width; i++) begin
      lane_rank[i] = lane_rank[i-1] + decode_pkg::cnt_w'(lane_valid[i-1]);
    end
  end

  assign valid_count = lane_rank[decode_pkg::issue_width-1]
                     + decode_pkg::cnt_w'(lane_valid[decode_pkg::issue_width-1]);
  assign any_valid   = |lane_valid;

  // The ROB and the IQ see the count minus one.
  assign count_m1       = valid_count - decode_pkg::cnt_w'(1);
  assign dispatch_count = count_m1[1:0];

  // ==========================================================================
  // Handshake
  // ==========================================================================

  assign stall    = rob_full | iq_full;
  assign dispatch = held_valid & any_valid & ~stall;
  assign pop      = held_valid & ~stall;  // An empty bundle just drains.

  // ==========================================================================
  // Compaction
  // ==========================================================================

  // Entry k takes the valid lane of rank k.
  always_comb begin
    for (int k = 0; k < decode_pkg::issue_width; k++) begin
      iq_entries[k].inst    = dec_lanes[decode_pkg::issue_width-1];  // Don't care past count.
      iq_entries[k].rob_tag = rob_tags[k];
      for (int j = 0; j < decode_pkg::issue_width; j++) begin
        if (lane_valid[j] && int'(lane_rank[j]) == k) begin
          iq_entries[k].inst = dec_lanes[j];
        end
      end
    end
  end

endmodule

//--- verilog/fetch_bundle_buffer.sv
`timescale 1ns/10ps

module fetch_bundle_buffer (
  input  logic                      clk,
  input  logic                      reset,
  input  decode_pkg::fetch_bundle_t in_bundle,
  input  logic                      in_valid,
  output logic                      in_ready,
  output decode_pkg::fetch_bundle_t held_bundle,
  output logic                      held_valid,
  input  logic                      pop
);

  logic load;

  // A new bundle can enter when the slot is empty or leaving this cycle.
  assign in_ready = ~held_valid | pop;
  assign load     = in_valid & in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else if (load) begin
      held_valid <= 1'b1;  // Replaces a popped bundle with no bubble.
    end else if (pop) begin
      held_valid <= 1'b0;
    end
  end

  // The payload loads together with the valid flag.
  always_ff @(posedge clk) begin
    if (load) begin
      held_bundle <= in_bundle;
    end
  end

endmodule

//--- verilog/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
  input  logic [decode_pkg::xlen-1:0] pc,
  input  logic [decode_pkg::xlen-1:0] inst_word,
  output decode_pkg::dec_inst_t       di
);

  decode_pkg::opcode_e     opcode;
  decode_pkg::inst_class_e cls;
  decode_pkg::class_use_t  uses;

  logic [decode_pkg::reg_idx_w-1:0] dest_field;
  logic [decode_pkg::reg_idx_w-1:0] a_field;
  logic [decode_pkg::reg_idx_w-1:0] b_field;
  logic [decode_pkg::reg_idx_w-1:0] c_field;
  logic [decode_pkg::imm_w-1:0]     imm_field;

  // Fixed format: opcode, dest, A, B, C. The immediate overlaps B and C.
  assign opcode     = decode_pkg::opcode_e'(inst_word[31:26]);
  assign dest_field = inst_word[25:21];
  assign a_field    = inst_word[20:16];
  assign b_field    = inst_word[15:11];
  assign c_field    = inst_word[10:6];
  assign imm_field  = inst_word[decode_pkg::imm_w-1:0];

  always_comb begin
    case (opcode[5:3])
      3'd0:    cls = decode_pkg::cls_alu;
      3'd1:    cls = decode_pkg::cls_alu_imm;
      3'd2:    cls = decode_pkg::cls_load;
      3'd3:    cls = decode_pkg::cls_store;
      3'd4:    cls = decode_pkg::cls_branch;
      default: cls = decode_pkg::cls_nop;  // Unassigned class codes.
    endcase
  end

  assign uses = decode_pkg::class_use(cls);

  always_comb begin
    di            = '0;
    di.cls        = cls;
    di.pc         = pc;
    di.dest_valid = uses.dest;
    di.a_used     = uses.a;
    di.b_used     = uses.b;
    di.c_used     = uses.c;
    // Unused index fields read as zero.
    if (uses.dest) di.dest_reg = dest_field;
    if (uses.a) di.a_reg = a_field;
    if (uses.b) di.b_reg = b_field;
    if (uses.c) di.c_reg = c_field;
    if (uses.imm) begin
      di.imm = {{(decode_pkg::xlen - decode_pkg::imm_w){imm_field[decode_pkg::imm_w-1]}},
                imm_field};
    end
  end

endmodule
